/* build.f */
source/gamePkg.sv
source/regPkg.sv
source/frameTimer.sv
source/bossRegs.sv
source/borderDetect.sv
source/bossMove.sv
source/bossTop.sv
tb/bossMove_sva.sv
tb/bossTb.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it, and judges the result from sim.log
rm -f sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module bossTb \
    -o bossSim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/bossSim > sim.log 2>&1
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "simulation ended early"; exit 1; }
echo "simulation passed"

/* source/borderDetect.sv */
`timescale 1ns/1ps

module borderDetect (
    input  logic clk,
    input  logic resetN,
    input  logic signed [gamePkg::PIXEL_WIDTH-1:0] topLeftX,
    input  logic signed [gamePkg::PIXEL_WIDTH-1:0] topLeftY,
    output logic borderCollision, // any edge touched
    output logic [gamePkg::EDGE_W-1:0] hitEdgeCode
);
    import gamePkg::*;

    // two extra bits so x + BOSS_W cannot wrap near the top of the range
    logic signed [PIXEL_WIDTH+1:0] rightX, bottomY;
    logic [EDGE_W-1:0] edgeNow; // unregistered compare result

    assign rightX = topLeftX + (PIXEL_WIDTH+2)'(BOSS_W);  // first column past the sprite
    assign bottomY = topLeftY + (PIXEL_WIDTH+2)'(BOSS_H); // first row past the sprite

    always_comb begin
        edgeNow = '0;
        edgeNow[EDGE_LEFT] = (topLeftX <= 0);
        edgeNow[EDGE_TOP] = (topLeftY <= 0);
        edgeNow[EDGE_RIGHT] = (rightX >= SCREEN_W);
        edgeNow[EDGE_BOTTOM] = (bottomY >= SCREEN_H); // a corner sets two bits at once
    end

    // one clock of latency, the mover sees the hit the cycle after the position moved
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            hitEdgeCode <= '0;
        end else begin
            hitEdgeCode <= edgeNow;
        end
    end

    assign borderCollision = |hitEdgeCode;

endmodule

/* source/bossMove.sv */
`timescale 1ns/1ps

module bossMove #(
    parameter int RESET_X = 300,      // position after reset, pixels
    parameter int RESET_Y = 200,
    parameter int RESET_SPEED_X = 24, // velocity after reset, 1/64 pixel per frame
    parameter int RESET_SPEED_Y = 24
) (
    input  logic clk,
    input  logic resetN,
    input  logic startOfFrame,
    input  logic run,
    input  logic reload,
    input  logic borderCollision,
    input  logic [gamePkg::EDGE_W-1:0] hitEdgeCode,
    input  logic signed [gamePkg::PIXEL_WIDTH-1:0] startX,
    input  logic signed [gamePkg::PIXEL_WIDTH-1:0] startY,
    input  logic signed [regPkg::SPEED_W-1:0] speedX,
    input  logic signed [regPkg::SPEED_W-1:0] speedY,
    output logic signed [gamePkg::PIXEL_WIDTH-1:0] topLeftX,
    output logic signed [gamePkg::PIXEL_WIDTH-1:0] topLeftY
);
    import gamePkg::*;
    import regPkg::*;

    logic signed [FIXED_W-1:0] posX, posY;   // whole pixels on top, FIXED_SHIFT fraction bits below
    logic signed [SPEED_W-1:0] velX, velY;   // live velocity, sign flips on a bounce
    logic flipX, flipY;

    // only bounce when heading into the wall, otherwise a sprite still
    // overlapping the edge after a reversal would flip straight back
    assign flipX = borderCollision &&
                   ((hitEdgeCode[EDGE_LEFT] && velX < 0) ||
                    (hitEdgeCode[EDGE_RIGHT] && velX > 0));
    assign flipY = borderCollision &&
                   ((hitEdgeCode[EDGE_TOP] && velY < 0) ||
                    (hitEdgeCode[EDGE_BOTTOM] && velY > 0));

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            posX <= FIXED_W'(RESET_X * (2 ** FIXED_SHIFT));
            posY <= FIXED_W'(RESET_Y * (2 ** FIXED_SHIFT));
            velX <= SPEED_W'(RESET_SPEED_X);
            velY <= SPEED_W'(RESET_SPEED_Y);
        end else if (reload) begin
            // reload wins over both motion and bounce
            posX <= {startX, {FIXED_SHIFT{1'b0}}}; // pixel times 64
            posY <= {startY, {FIXED_SHIFT{1'b0}}};
            velX <= speedX;
            velY <= speedY;
        end else begin
            if (startOfFrame && run) begin
                posX <= posX + velX; // velocity is sign extended to the position width
                posY <= posY + velY;
            end
            if (flipX) begin
                velX <= -velX;
            end
            if (flipY) begin
                velY <= -velY;
            end
        end
    end

    // dropping the fraction bits is an arithmetic shift, so negative positions round down
    assign topLeftX = posX[FIXED_W-1:FIXED_SHIFT];
    assign topLeftY = posY[FIXED_W-1:FIXED_SHIFT];

endmodule

/* source/bossRegs.sv */
`timescale 1ns/1ps

module bossRegs #(
    parameter int RESET_X = 300,      // start pixel after reset
    parameter int RESET_Y = 200,
    parameter int RESET_SPEED_X = 24, // start speed after reset, 1/64 pixel per frame
    parameter int RESET_SPEED_Y = 24
) (
    input  logic clk,
    input  logic resetN,
    input  logic pSel,
    input  logic pEnable,
    input  logic pWrite,
    input  logic [regPkg::ADDR_W-1:0] pAddr,
    input  logic [regPkg::DATA_W-1:0] pWdata,
    output logic [regPkg::DATA_W-1:0] pRdata,
    output logic pSlverr,
    input  logic signed [gamePkg::PIXEL_WIDTH-1:0] topLeftX, // live position for readback
    input  logic signed [gamePkg::PIXEL_WIDTH-1:0] topLeftY,
    input  logic [gamePkg::EDGE_W-1:0] hitEdgeCode,
    input  logic borderCollision,
    output logic run,
    output logic reload, // one clock pulse after a CTRL write with bit 1 set
    output logic signed [gamePkg::PIXEL_WIDTH-1:0] startX,
    output logic signed [gamePkg::PIXEL_WIDTH-1:0] startY,
    output logic signed [regPkg::SPEED_W-1:0] speedX,
    output logic signed [regPkg::SPEED_W-1:0] speedY
);
    import regPkg::*;
    import gamePkg::*;

    logic access;  // APB access phase, the only cycle that counts
    logic addrKnown;
    logic wrOk;    // write that is allowed to land
    logic [DATA_W-1:0] readWord;
    logic [FIELD_W-1:0] startXReg, startYReg; // full 16 bit fields so readback is exact
    logic [EDGE_W-1:0] status;
    logic [EDGE_W-1:0] clearMask, setMask;

    assign access = pSel && pEnable;
    assign pSlverr = access && (!addrKnown || (pWrite && pAddr == ADDR_POS)); // POS is read only
    assign wrOk = access && pWrite && !pSlverr;
    assign pRdata = (access && !pWrite && addrKnown) ? readWord : '0;

    // the mover only needs the pixel range of the start fields
    assign startX = signed'(startXReg[PIXEL_WIDTH-1:0]);
    assign startY = signed'(startYReg[PIXEL_WIDTH-1:0]);

    assign clearMask = (wrOk && pAddr == ADDR_STATUS) ? pWdata[EDGE_W-1:0] : '0;
    assign setMask = borderCollision ? hitEdgeCode : '0;

    always_comb begin
        addrKnown = 1'b1;
        readWord = '0;
        case (pAddr)
            ADDR_CTRL: readWord[CTRL_RUN_BIT] = run; // reload bit always reads back 0
            ADDR_SPEED: begin
                readWord[FIELD_X_LSB +: SPEED_W] = speedX;
                readWord[FIELD_Y_LSB +: SPEED_W] = speedY;
            end
            ADDR_START: begin
                readWord[FIELD_X_LSB +: FIELD_W] = startXReg;
                readWord[FIELD_Y_LSB +: FIELD_W] = startYReg;
            end
            ADDR_POS: begin // sign extend the pixel position into each half
                readWord[FIELD_X_LSB +: FIELD_W] = {{(FIELD_W-PIXEL_WIDTH){topLeftX[PIXEL_WIDTH-1]}}, topLeftX};
                readWord[FIELD_Y_LSB +: FIELD_W] = {{(FIELD_W-PIXEL_WIDTH){topLeftY[PIXEL_WIDTH-1]}}, topLeftY};
            end
            ADDR_STATUS: readWord[EDGE_W-1:0] = status;
            default: addrKnown = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            run <= 1'b0;
            reload <= 1'b0;
            speedX <= SPEED_W'(RESET_SPEED_X);
            speedY <= SPEED_W'(RESET_SPEED_Y);
            startXReg <= FIELD_W'(RESET_X);
            startYReg <= FIELD_W'(RESET_Y);
            status <= '0;
        end else begin
            reload <= 1'b0; // pulse lasts a single clock
            if (wrOk) begin
                case (pAddr)
                    ADDR_CTRL: begin
                        run <= pWdata[CTRL_RUN_BIT];
                        reload <= pWdata[CTRL_RELOAD_BIT];
                    end
                    ADDR_SPEED: begin
                        speedX <= pWdata[FIELD_X_LSB +: SPEED_W];
                        speedY <= pWdata[FIELD_Y_LSB +: SPEED_W];
                    end
                    ADDR_START: begin
                        startXReg <= pWdata[FIELD_X_LSB +: FIELD_W];
                        startYReg <= pWdata[FIELD_Y_LSB +: FIELD_W];
                    end
                    default: ; // STATUS is handled through clearMask below
                endcase
            end
            status <= (status & ~clearMask) | setMask; // a new hit beats a clear
        end
    end

endmodule

/* source/bossTop.sv */
`timescale 1ns/1ps

module bossTop #(
    parameter int unsigned FRAME_CYCLES = 416_666, // clocks per frame
    parameter int RESET_X = 300,
    parameter int RESET_Y = 200,
    parameter int RESET_SPEED_X = 24,
    parameter int RESET_SPEED_Y = 24
) (
    input  logic clk,
    input  logic resetN,
    input  logic pSel,
    input  logic pEnable,
    input  logic pWrite,
    input  logic [regPkg::ADDR_W-1:0] pAddr,
    input  logic [regPkg::DATA_W-1:0] pWdata,
    output logic [regPkg::DATA_W-1:0] pRdata,
    output logic pSlverr,
    output logic signed [gamePkg::PIXEL_WIDTH-1:0] topLeftX,
    output logic signed [gamePkg::PIXEL_WIDTH-1:0] topLeftY,
    output logic frameStart // copy of the frame pulse for whoever draws the frame
);
    import gamePkg::*;
    import regPkg::*;

    logic startOfFrame;
    logic run, reload;
    logic borderCollision;
    logic [EDGE_W-1:0] hitEdgeCode;
    logic signed [PIXEL_WIDTH-1:0] startX, startY;
    logic signed [SPEED_W-1:0] speedX, speedY;

    assign frameStart = startOfFrame;

    frameTimer #(.FRAME_CYCLES(FRAME_CYCLES)) frameTimer_i (
        .clk, .resetN, .startOfFrame
    );

    // register block steers the mover and reads its position back
    bossRegs #(
        .RESET_X(RESET_X), .RESET_Y(RESET_Y),
        .RESET_SPEED_X(RESET_SPEED_X), .RESET_SPEED_Y(RESET_SPEED_Y)
    ) bossRegs_i (
        .clk, .resetN, .pSel, .pEnable, .pWrite, .pAddr, .pWdata, .pRdata, .pSlverr,
        .topLeftX, .topLeftY, .hitEdgeCode, .borderCollision,
        .run, .reload, .startX, .startY, .speedX, .speedY
    );

    borderDetect borderDetect_i (
        .clk, .resetN, .topLeftX, .topLeftY, .borderCollision, .hitEdgeCode
    );

    bossMove #(
        .RESET_X(RESET_X), .RESET_Y(RESET_Y),
        .RESET_SPEED_X(RESET_SPEED_X), .RESET_SPEED_Y(RESET_SPEED_Y)
    ) bossMove_i (
        .clk, .resetN, .startOfFrame, .run, .reload, .borderCollision, .hitEdgeCode,
        .startX, .startY, .speedX, .speedY, .topLeftX, .topLeftY
    );

endmodule

/* source/frameTimer.sv */
`timescale 1ns/1ps

module frameTimer #(
    parameter int unsigned FRAME_CYCLES = 416_666 // clocks per video frame
) (
    input  logic clk,
    input  logic resetN,
    output logic startOfFrame // one clock wide, once per frame
);

    // counter just wide enough to reach FRAME_CYCLES - 1
    localparam int CNT_W = (FRAME_CYCLES > 1) ? $clog2(FRAME_CYCLES) : 1;

    logic [CNT_W-1:0] cycleCnt;
    logic wrapNow;

    assign wrapNow = (cycleCnt == CNT_W'(FRAME_CYCLES - 1)); // last clock of the frame

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            cycleCnt <= '0;
            startOfFrame <= 1'b0;
        end else begin
            cycleCnt <= wrapNow ? '0 : cycleCnt + 1'b1; // modulo FRAME_CYCLES
            startOfFrame <= wrapNow; // so the first pulse lands FRAME_CYCLES clocks after reset
        end
    end

endmodule

/* source/gamePkg.sv */
package gamePkg;

    // pixel coordinates are signed so the sprite may sit partly off screen
    localparam int PIXEL_WIDTH = 11; // covers -1024 .. 1023 pixels

    // motion is kept in 1/64 pixel steps
    localparam int FIXED_SHIFT = 6; // 2**6 sub-pixels per pixel
    localparam int FIXED_W = PIXEL_WIDTH + FIXED_SHIFT; // whole fixed-point word

    // visible screen in pixels
    localparam int SCREEN_W = 640;
    localparam int SCREEN_H = 480;

    // the boss sprite box, measured from its top-left corner
    localparam int BOSS_W = 64;
    localparam int BOSS_H = 64;

    // the edge code carries one flag per screen side
    localparam int EDGE_W = 4;

    // bit positions inside the edge code, same order as the status register
    localparam int EDGE_LEFT = 3;   // x at or past the left border
    localparam int EDGE_TOP = 2;    // y at or past the top border
    localparam int EDGE_RIGHT = 1;  // right side of the box reaches SCREEN_W
    localparam int EDGE_BOTTOM = 0; // bottom side of the box reaches SCREEN_H

    // left and right only ever touch the X speed, top and bottom only the Y speed
    // so the mover can look at two bits per axis

endpackage

/* source/regPkg.sv */
package regPkg;

    // APB bus widths
    localparam int ADDR_W = 8;  // byte address, word aligned registers
    localparam int DATA_W = 32;

    // width of one speed field, signed, in 1/64 pixel per frame
    localparam int SPEED_W = 16;

    // SPEED, START and POS all split the word into two 16 bit halves
    localparam int FIELD_W = 16;
    localparam int FIELD_X_LSB = 0;  // X sits in the low half
    localparam int FIELD_Y_LSB = 16; // Y sits in the high half

    // CTRL bits
    localparam int CTRL_RUN_BIT = 0;    // held, lets the sprite move
    localparam int CTRL_RELOAD_BIT = 1; // self clearing, reads back as 0

    // register map
    localparam logic [ADDR_W-1:0] ADDR_CTRL = 8'h00;   // run and reload
    localparam logic [ADDR_W-1:0] ADDR_SPEED = 8'h04;  // start speed, X and Y
    localparam logic [ADDR_W-1:0] ADDR_START = 8'h08;  // start pixel, X and Y
    localparam logic [ADDR_W-1:0] ADDR_POS = 8'h0C;    // live position, read only
    localparam logic [ADDR_W-1:0] ADDR_STATUS = 8'h10; // sticky edge hits, write 1 to clear

    // any other address answers with pSlverr
    // so does a write to POS

    // the status word reuses the edge code order from gamePkg
    // bit 3 left, bit 2 top, bit 1 right, bit 0 bottom
    // unused upper bits of CTRL and STATUS read as zero
    // writes to them are ignored

endpackage

/* tb/bossMove_sva.sv */
`timescale 1ns/1ps

module bossMove_sva (
    input logic clk,
    input logic resetN,
    input logic startOfFrame,
    input logic reload,
    input logic borderCollision,
    input logic signed [gamePkg::PIXEL_WIDTH-1:0] startX,
    input logic signed [gamePkg::PIXEL_WIDTH-1:0] startY,
    input logic signed [gamePkg::PIXEL_WIDTH-1:0] topLeftX,
    input logic signed [gamePkg::PIXEL_WIDTH-1:0] topLeftY,
    input logic signed [regPkg::SPEED_W-1:0] velX, // live velocity inside the mover
    input logic signed [regPkg::SPEED_W-1:0] velY
);

    framePulseShort: assert property (@(posedge clk) disable iff (!resetN)
        startOfFrame |=> !startOfFrame) // a frame pulse never lasts two clocks
        else $error("startOfFrame stayed high for two cycles");

    // reload copies the start pixel straight into the position
    reloadLoads: assert property (@(posedge clk) disable iff (!resetN)
        reload |=> (topLeftX == $past(startX) && topLeftY == $past(startY)))
        else $error("position differs from the start value after reload");

    // apart from a reload the velocity only changes when a wall was hit
    bounceOnlyX: assert property (@(posedge clk) disable iff (!resetN)
        (velX != $past(velX) && !$past(reload)) |-> $past(borderCollision))
        else $error("velX changed without a border collision");

    bounceOnlyY: assert property (@(posedge clk) disable iff (!resetN)
        (velY != $past(velY) && !$past(reload)) |-> $past(borderCollision))
        else $error("velY changed without a border collision");

endmodule

/* tb/bossTb.sv */
`timescale 1ns/1ps

module bossTb;
    import gamePkg::*;
    import regPkg::*;

    localparam int FRAME_CYCLES = 16; // short frames keep the run fast
    localparam int FIX = 2 ** FIXED_SHIFT;

    logic clk = 1'b0;
    logic resetN, pSel, pEnable, pWrite, pSlverr, frameStart;
    logic [ADDR_W-1:0] pAddr;
    logic [DATA_W-1:0] pWdata, pRdata;
    logic signed [PIXEL_WIDTH-1:0] topLeftX, topLeftY;

    int unsigned lcgState = 32'hec31;
    int errCount = 0, checkCount = 0, testErrs = 0, testNum = 0;
    int clocksSinceFrame = 0; // negedges since the last frame pulse or the release of reset
    int modelX, modelY, modelVx, modelVy; // reference state in 1/64 pixel
    int speedXw, speedYw; // last speeds written to SPEED
    bit modelRun = 1'b0;
    logic [EDGE_W-1:0] modelStatus = '0;
    logic [DATA_W-1:0] rd, word;
    logic err;

    bossTop #(.FRAME_CYCLES(FRAME_CYCLES)) dut_i (.*);

    bind bossMove bossMove_sva sva_i (.clk, .resetN, .startOfFrame, .reload, .borderCollision,
        .startX, .startY, .topLeftX, .topLeftY, .velX, .velY);

    always #10 clk = ~clk; // 20 ns period

    // every frame pulse comes FRAME_CYCLES clocks after the previous one or after reset
    always @(negedge clk) begin
        if (!resetN) begin
            clocksSinceFrame = 0;
        end else if (frameStart) begin
            checkEq("frameStart period", FRAME_CYCLES, clocksSinceFrame);
            clocksSinceFrame = 1;
        end else begin
            clocksSinceFrame++;
        end
    end

    function automatic int unsigned nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223; // callers shift down the strong top bits
        return lcgState;
    endfunction

    function automatic int randSpeed(int minMag, int span);
        int mag;
        mag = minMag + int'((nextRand() >> 16) % span);
        return ((nextRand() >> 20) & 1) ? -mag : mag; // either direction
    endfunction

    // edge rule applied to the floor of the fixed-point position
    function automatic logic [EDGE_W-1:0] edgesOf(int fx, int fy);
        logic [EDGE_W-1:0] e;
        e = '0;
        e[EDGE_LEFT] = (fx >>> FIXED_SHIFT) <= 0;
        e[EDGE_TOP] = (fy >>> FIXED_SHIFT) <= 0;
        e[EDGE_RIGHT] = (fx >>> FIXED_SHIFT) + BOSS_W >= SCREEN_W;
        e[EDGE_BOTTOM] = (fy >>> FIXED_SHIFT) + BOSS_H >= SCREEN_H;
        return e;
    endfunction

    function automatic void bounceModel();
        logic [EDGE_W-1:0] e;
        e = edgesOf(modelX, modelY);
        if ((e[EDGE_LEFT] && modelVx < 0) || (e[EDGE_RIGHT] && modelVx > 0))
            modelVx = -modelVx; // only when heading into the wall
        if ((e[EDGE_TOP] && modelVy < 0) || (e[EDGE_BOTTOM] && modelVy > 0))
            modelVy = -modelVy;
        modelStatus |= e; // status is sticky
    endfunction

    task automatic checkEq(string name, logic [31:0] expected, logic [31:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errCount++;
            $display("ERR %0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic apbWrite(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            output logic slvErr);
        @(posedge clk);
        pSel <= 1'b1;
        pEnable <= 1'b0;
        pWrite <= 1'b1;
        pAddr <= addr;
        pWdata <= data;
        @(posedge clk);
        pEnable <= 1'b1; // the write lands on the edge that closes the access phase
        @(negedge clk);
        slvErr = pSlverr;
        @(posedge clk);
        pSel <= 1'b0;
        pEnable <= 1'b0;
        pWrite <= 1'b0;
    endtask

    task automatic apbRead(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                           output logic slvErr);
        @(posedge clk);
        pSel <= 1'b1;
        pEnable <= 1'b0;
        pWrite <= 1'b0;
        pAddr <= addr;
        @(posedge clk);
        pEnable <= 1'b1;
        @(negedge clk);
        data = pRdata; // read data is combinational in the access phase
        slvErr = pSlverr;
        @(posedge clk);
        pSel <= 1'b0;
        pEnable <= 1'b0;
    endtask

    task automatic expectWrite(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                               input logic errExp);
        logic slvErr;
        apbWrite(addr, data, slvErr);
        checkEq("pSlverr", errExp, slvErr);
    endtask

    task automatic expectRead(input logic [ADDR_W-1:0] addr, input string name,
                              input logic [DATA_W-1:0] expected);
        logic [DATA_W-1:0] data;
        logic slvErr;
        apbRead(addr, data, slvErr);
        checkEq(name, expected, data);
        checkEq("pSlverr", 0, slvErr);
    endtask

    // returns one negedge after the clock edge that consumed the pulse
    task automatic waitFrame();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!frameStart && waited < 2 * FRAME_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (!frameStart) begin
            errCount++;
            $display("frameStart did not pulse within %0d cycles", 2 * FRAME_CYCLES);
        end else if (modelRun) begin
            modelX += modelVx;
            modelY += modelVy;
        end
        bounceModel();
        @(negedge clk);
    endtask

    task automatic loadStart(int sx, int sy, int vx, int vy);
        speedXw = vx;
        speedYw = vy;
        expectWrite(ADDR_START, {16'(sy), 16'(sx)}, 1'b0);
        expectWrite(ADDR_SPEED, {16'(vy), 16'(vx)}, 1'b0);
        waitFrame(); // keeps the reload clear of the frame pulse
        expectWrite(ADDR_CTRL, {30'd0, 1'b1, modelRun}, 1'b0);
        modelX = sx * FIX;
        modelY = sy * FIX;
        modelVx = vx;
        modelVy = vy;
        bounceModel();
    endtask

    task automatic comparePos();
        checkEq("topLeftX", modelX >>> FIXED_SHIFT, topLeftX);
        checkEq("topLeftY", modelY >>> FIXED_SHIFT, topLeftY);
    endtask

    task automatic endTest(string name);
        testNum++;
        $display("test %0d %s: %0d errors", testNum, name, errCount - testErrs);
        testErrs = errCount;
    endtask

    initial begin
        resetN = 1'b0;
        pSel = 1'b0;
        pEnable = 1'b0;
        pWrite = 1'b0;
        pAddr = '0;
        pWdata = '0;
        modelX = 300 * FIX;
        modelY = 200 * FIX;
        modelVx = 24;
        modelVy = 24;
        repeat (16) @(posedge clk);
        resetN <= 1'b1;

        expectRead(ADDR_CTRL, "CTRL", 0);
        expectRead(ADDR_SPEED, "SPEED", {16'd24, 16'd24});
        expectRead(ADDR_START, "START", {16'd200, 16'd300});
        expectRead(ADDR_POS, "POS", {16'd200, 16'd300});
        expectRead(ADDR_STATUS, "STATUS", 0);
        endTest("reset values");

        word = nextRand();
        expectWrite(ADDR_SPEED, word, 1'b0);
        expectRead(ADDR_SPEED, "SPEED", word);
        expectWrite(ADDR_START, ~word, 1'b0);
        expectRead(ADDR_START, "START", ~word);
        apbRead(8'h14 + 8'((nextRand() >> 16) % 59) * 8'd4, rd, err);
        checkEq("pSlverr", 1, err);
        expectWrite(8'h14 + 8'((nextRand() >> 16) % 59) * 8'd4, nextRand(), 1'b1);
        expectWrite(ADDR_POS, nextRand(), 1'b1);
        expectRead(ADDR_CTRL, "CTRL", 0);
        expectRead(ADDR_SPEED, "SPEED", word);
        expectRead(ADDR_START, "START", ~word);
        expectRead(ADDR_POS, "POS", {16'd200, 16'd300});
        expectRead(ADDR_STATUS, "STATUS", 0);
        endTest("register access");

        modelRun = 1'b1; // the CTRL write in loadStart sets run together with reload
        loadStart(288, 208, randSpeed(0, 128), randSpeed(0, 128));
        repeat (8) begin
            waitFrame();
            comparePos();
        end
        endTest("straight motion");

        loadStart(288, 208, randSpeed(320, 193), randSpeed(320, 193)); // 5 to 8 pixels per frame
        repeat (200) begin
            waitFrame();
            comparePos();
        end
        expectRead(ADDR_STATUS, "STATUS", 4'hf); // every wall was reached
        endTest("bounces");

        waitFrame();
        expectWrite(ADDR_CTRL, 0, 1'b0);
        modelRun = 1'b0;
        repeat (3) begin
            waitFrame();
            comparePos(); // frozen
        end
        expectRead(ADDR_STATUS, "STATUS", modelStatus);
        loadStart(288, 208, speedXw, speedYw); // back to the middle where no wall is touched
        waitFrame();
        comparePos();
        expectRead(ADDR_STATUS, "STATUS", modelStatus);
        expectWrite(ADDR_STATUS, 32'hf, 1'b0);
        expectRead(ADDR_STATUS, "STATUS", 0);
        endTest("run and status");

        $display("checks %0d, errors %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
